// File: files.f
rtl/nocPkg.sv
rtl/holdTimer.sv
rtl/outputArbiter.sv
rtl/flitSwitch.sv
rtl/outputPortTop.sv
test/outputPort_props.sv
test/outputPortTb.sv

// File: Bender.yml
package:
  name: noc_output_port

sources:
  # design, package first
  - files:
      - rtl/nocPkg.sv
      - rtl/holdTimer.sv
      - rtl/outputArbiter.sv
      - rtl/flitSwitch.sv
      - rtl/outputPortTop.sv

  # simulation only
  - target: test
    files:
      - test/outputPort_props.sv
      - test/outputPortTb.sv

// File: test/outputPortTb.sv
`timescale 1ns/10ps
`default_nettype none

module outputPortTb;
  import nocPkg::*;

  localparam int ClkPeriod = 10;
  localparam int DirectedCycles = 120;
  localparam int RandCycles = 300;
  localparam int MarginCycles = 200;

  logic                clk;
  logic                rst;
  portIn_t             inPorts [NumPorts];
  logic [NumPorts-1:0] grant;
  flit_u               outFlit;
  logic                outValid;

  string               testName;
  int                  errorCount = 0;
  int                  checkCount = 0;

  // model state holds -1 for idle or the granted port 0..4
  int                  mState;
  logic [LenWidth-1:0] mLimit [NumPorts];
  logic [LenWidth-1:0] mCount [NumPorts];
  flit_u               expFlit;
  logic                expValid;

  outputPortTop outputPortTop_i
  (
    .clk      (clk),
    .rst      (rst),
    .inPorts  (inPorts),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  bind outputPortTop outputPort_props outputPort_props_i
  (
    .clk      (clk),
    .rst      (rst),
    .inPorts  (inPorts),
    .grant    (grant),
    .outValid (outValid)
  );

  // next owner of the output under the hold and rotation rules
  function automatic int nextPort(input int cur, input logic [NumPorts-1:0] reqs,
                                  input logic [NumPorts-1:0] ups);
    int j;
    if (cur < 0)
    begin
      for (int i = 0; i < NumPorts; i++)
      begin
        if (reqs[i])
          return i;
      end
      return -1;
    end
    if (reqs[cur] && !ups[cur])
      return cur;
    for (int k = 1; k < NumPorts; k++)
    begin
      j = (cur + k) % NumPorts;
      if (reqs[j])
        return j;
    end
    return -1;
  endfunction

  function automatic flit_u headFlit(input int len);
    flit_u f;
    f = '0;
    f.head.id = HEAD;
    f.head.len = LenWidth'(len);
    return f;
  endfunction

  function automatic flit_u bodyFlit(input logic [PayloadWidth-1:0] payload);
    flit_u f;
    f.body.id = BODY;
    f.body.payload = payload;
    return f;
  endfunction

  function automatic int portOf(input logic [NumPorts-1:0] g);
    for (int i = 0; i < NumPorts; i++)
    begin
      if (g[i])
        return i;
    end
    return -1;
  endfunction

  task automatic clearInputs();
    for (int i = 0; i < NumPorts; i++)
      inPorts[i] = '0;
  endtask

  // counts the falling edges over which port p keeps one grant
  task automatic measureHold(input int p, input int expected);
    int cycles;
    cycles = 0;
    while (!grant[p])
      @(negedge clk);
    while (grant[p])
    begin
      cycles++;
      @(negedge clk);
    end
    assert (cycles == expected)
    else
    begin
      $display("FAIL %s hold cycles expected %0d actual %0d", testName, expected, cycles);
      errorCount++;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin : compareModel
    logic [NumPorts-1:0] reqs;
    logic [NumPorts-1:0] ups;
    logic [NumPorts-1:0] expGrant;
    int                  nxt;
    if (rst)
    begin
      mState = -1;
      expFlit = '0;
      expValid = 1'b0;
      for (int i = 0; i < NumPorts; i++)
      begin
        mLimit[i] = '0;
        mCount[i] = '0;
      end
    end
    else
    begin
      expGrant = '0;
      if (mState >= 0)
        expGrant[mState] = 1'b1;
      assert (grant == expGrant)
      else
      begin
        $display("FAIL %s grant expected %b actual %b", testName, expGrant, grant);
        errorCount++;
      end
      assert (outValid == expValid)
      else
      begin
        $display("FAIL %s outValid expected %b actual %b", testName, expValid, outValid);
        errorCount++;
      end
      assert (outFlit == expFlit)
      else
      begin
        $display("FAIL %s outFlit expected %h actual %h", testName, expFlit, outFlit);
        errorCount++;
      end
      checkCount += 3;
      for (int i = 0; i < NumPorts; i++)
      begin
        reqs[i] = inPorts[i].req;
        ups[i] = (mCount[i] == mLimit[i]);
      end
      nxt = nextPort(mState, reqs, ups);
      // switch register takes the granted flit only while its owner requests
      if (mState >= 0 && reqs[mState])
      begin
        expFlit = inPorts[mState].flit;
        expValid = 1'b1;
      end
      else
      begin
        expFlit = '0;
        expValid = 1'b0;
      end
      for (int i = 0; i < NumPorts; i++)
      begin
        mCount[i] = (i == mState && reqs[i] && !ups[i]) ? mCount[i] + 1'b1 : '0;
        if (inPorts[i].flit.head.id == HEAD)
          mLimit[i] = inPorts[i].flit.head.len;
      end
      mState = nxt;
    end
  end

  initial
  begin
    #((DirectedCycles + RandCycles + MarginCycles) * ClkPeriod);
    $display("timeout: the run did not end within the expected number of cycles");
    $display("Test failed");
    $finish;
  end

  initial
  begin : stimulus
    int          last;
    int          idx;
    int unsigned r;
    void'($urandom(32'h9a41));
    rst = 1'b1;
    clearInputs();
    testName = "reset";
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (5) @(negedge clk);

    testName = "idlePriority";
    inPorts[South] = '{req: 1'b1, flit: headFlit(2)};
    inPorts[West] = '{req: 1'b1, flit: headFlit(2)};
    inPorts[North] = '{req: 1'b1, flit: headFlit(1)};
    @(negedge clk);
    clearInputs();
    repeat (3) @(negedge clk);

    testName = "holdLength";
    for (int len = 0; len <= 3; len += 3)
    begin
      inPorts[Local] = '{req: 1'b1, flit: headFlit(len)};
      @(negedge clk);
      inPorts[Local].flit = bodyFlit(PayloadWidth'($urandom));
      measureHold(Local, len + 1);
      // one idle cycle before the still requesting port wins again
      @(negedge clk);
      clearInputs();
      repeat (2) @(negedge clk);
    end

    testName = "rotation";
    for (int i = 0; i < NumPorts; i++)
      inPorts[i] = '{req: 1'b1, flit: headFlit(1)};
    @(negedge clk);
    for (int i = 0; i < NumPorts; i++)
      inPorts[i].flit = bodyFlit(PayloadWidth'(i));
    last = -1;
    repeat (25)
    begin
      @(negedge clk);
      idx = portOf(grant);
      if (idx >= 0 && idx != last)
      begin
        if (last >= 0)
        begin
          assert (idx == (last + 1) % NumPorts)
          else
          begin
            $display("FAIL %s next port expected %0d actual %0d", testName,
                     (last + 1) % NumPorts, idx);
            errorCount++;
          end
        end
        last = idx;
      end
    end
    clearInputs();
    repeat (2) @(negedge clk);

    testName = "passThrough";
    inPorts[West] = '{req: 1'b1, flit: headFlit(6)};
    repeat (6)
    begin
      @(negedge clk);
      inPorts[West].flit = bodyFlit(PayloadWidth'($urandom));
    end
    clearInputs();
    repeat (3) @(negedge clk);

    testName = "lengthLatch";
    inPorts[East] = '{req: 1'b1, flit: headFlit(1)};
    @(negedge clk);
    inPorts[East].flit = bodyFlit('0);
    measureHold(East, 2);
    // body payload that would read as length 5 in the head view
    inPorts[East] = '{req: 1'b0, flit: bodyFlit(PayloadWidth'(5 << 1))};
    @(negedge clk);
    inPorts[East].req = 1'b1;
    @(negedge clk);
    measureHold(East, 2);
    clearInputs();
    repeat (2) @(negedge clk);

    testName = "random";
    repeat (RandCycles)
    begin
      for (int i = 0; i < NumPorts; i++)
      begin
        r = $urandom;
        inPorts[i].req = (r % 3) != 0;
        if ((r >> 4) % 4 == 0)
          inPorts[i].flit = headFlit($urandom % 7);
        else
        begin
          inPorts[i].flit = bodyFlit(PayloadWidth'($urandom));
          inPorts[i].flit.body.id = r[8] ? BODY : TAIL;
        end
      end
      @(negedge clk);
    end
    clearInputs();
    repeat (3) @(negedge clk);

    $display("checks %0d, model errors %0d, property errors %0d", checkCount, errorCount,
             outputPortTop_i.outputPort_props_i.propFails);
    if (errorCount == 0 && outputPortTop_i.outputPort_props_i.propFails == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/outputPort_props.sv
`timescale 1ns/10ps
`default_nettype none

module outputPort_props
(
  input logic                        clk,
  input logic                        rst,
  input nocPkg::portIn_t             inPorts [nocPkg::NumPorts],
  input logic [nocPkg::NumPorts-1:0] grant,
  input logic                        outValid
);
  import nocPkg::*;

  int propFails = 0;

  // at most one input owns the output
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    $error("grant has more than one bit set");
    propFails++;
  end

  for (genvar i = 0; i < NumPorts; i++)
  begin : gRise
    grantAfterReq: assert property (@(posedge clk) disable iff (rst)
      $rose(grant[i]) |-> $past(inPorts[i].req))
    else
    begin
      $error("grant given to port %0d that did not request", i);
      propFails++;
    end
  end

  // the switch register only fills behind a grant
  validAfterGrant: assert property (@(posedge clk) disable iff (rst)
    outValid |-> $past(|grant))
  else
  begin
    $error("outValid high without a grant in the cycle before");
    propFails++;
  end

endmodule

`default_nettype wire

// File: rtl/outputPortTop.sv
`timescale 1ns/10ps
`default_nettype none

module outputPortTop
(
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::portIn_t             inPorts [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0] grant,
  output nocPkg::flit_u               outFlit,
  output logic                        outValid
);

  // grant decision for this output port
  outputArbiter outputArbiter_i
  (
    .clk     (clk),
    .rst     (rst),
    .inPorts (inPorts),
    .grant   (grant)
  );

  // registered crossbar column driven by the grant
  flitSwitch flitSwitch_i
  (
    .clk      (clk),
    .rst      (rst),
    .inPorts  (inPorts),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

// File: rtl/flitSwitch.sv
`timescale 1ns/10ps
`default_nettype none

module flitSwitch
(
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::portIn_t             inPorts [nocPkg::NumPorts],
  input  logic [nocPkg::NumPorts-1:0] grant,
  output nocPkg::flit_u               outFlit,
  output logic                        outValid
);
  import nocPkg::*;

  flit_u selFlit;
  logic  selValid;

  // grant is one-hot or zero, so at most one input is picked
  always_comb
  begin
    selFlit = '0;
    selValid = 1'b0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i])
      begin
        selFlit = inPorts[i].flit;
        selValid = inPorts[i].req;
      end
    end
  end

  // single output register, the flit is passed through untouched
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= '0;
      outValid <= 1'b0;
    end
    else if (selValid)
    begin
      outFlit <= selFlit;
      outValid <= 1'b1;
    end
    else
    begin
      // output word reads zero whenever nothing is forwarded
      outFlit <= '0;
      outValid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/outputArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module outputArbiter
(
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::portIn_t             inPorts [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0] grant
);
  import nocPkg::*;

  localparam int StateWidth = NumPorts + 1;

  // one-hot state, bit 0 is idle, bits 1..5 grant Local..South
  localparam logic [StateWidth-1:0] IdleState  = 6'b000001;
  localparam logic [StateWidth-1:0] GrantLocal = 6'b000010;
  localparam logic [StateWidth-1:0] GrantNorth = 6'b000100;
  localparam logic [StateWidth-1:0] GrantEast  = 6'b001000;
  localparam logic [StateWidth-1:0] GrantWest  = 6'b010000;
  localparam logic [StateWidth-1:0] GrantSouth = 6'b100000;

  logic [StateWidth-1:0] state;
  logic [StateWidth-1:0] nextState;
  logic [NumPorts-1:0]   req;
  logic [NumPorts-1:0]   runTimer;
  logic [NumPorts-1:0]   timesUp;

  // first requester among the span ports that follow last in the rotation
  function automatic logic [StateWidth-1:0] pickAfter
  (
    input logic [NumPorts-1:0] reqs,
    input int unsigned         last,
    input int unsigned         span
  );
    int unsigned idx;
    logic        found;
    begin
      pickAfter = IdleState;
      found = 1'b0;
      for (int unsigned k = 1; k <= span; k++)
      begin
        idx = (last + k) % NumPorts;
        if (!found && reqs[idx])
        begin
          pickAfter = StateWidth'(1) << (idx + 1);
          found = 1'b1;
        end
      end
    end
  endfunction

  for (genvar i = 0; i < NumPorts; i++)
  begin : gTimer
    assign req[i] = inPorts[i].req;

    holdTimer holdTimer_i
    (
      .clk      (clk),
      .rst      (rst),
      .inFlit   (inPorts[i].flit),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IdleState;
    end
    else
    begin
      state <= nextState;
    end
  end

  // hold while the owner requests and its timer runs, else rotate onward
  always_comb
  begin
    runTimer = '0;
    nextState = IdleState;
    case (state)
      IdleState:
      begin
        // starting after South makes Local the first candidate
        nextState = pickAfter(req, South, NumPorts);
      end
      GrantLocal:
      begin
        if (req[Local] && !timesUp[Local])
        begin
          runTimer[Local] = 1'b1;
          nextState = GrantLocal;
        end
        else
        begin
          nextState = pickAfter(req, Local, NumPorts - 1);
        end
      end
      GrantNorth:
      begin
        if (req[North] && !timesUp[North])
        begin
          runTimer[North] = 1'b1;
          nextState = GrantNorth;
        end
        else
        begin
          nextState = pickAfter(req, North, NumPorts - 1);
        end
      end
      GrantEast:
      begin
        if (req[East] && !timesUp[East])
        begin
          runTimer[East] = 1'b1;
          nextState = GrantEast;
        end
        else
        begin
          nextState = pickAfter(req, East, NumPorts - 1);
        end
      end
      GrantWest:
      begin
        if (req[West] && !timesUp[West])
        begin
          runTimer[West] = 1'b1;
          nextState = GrantWest;
        end
        else
        begin
          nextState = pickAfter(req, West, NumPorts - 1);
        end
      end
      GrantSouth:
      begin
        if (req[South] && !timesUp[South])
        begin
          runTimer[South] = 1'b1;
          nextState = GrantSouth;
        end
        else
        begin
          nextState = pickAfter(req, South, NumPorts - 1);
        end
      end
      default:
      begin
        // not one-hot, recover through idle
        nextState = IdleState;
      end
    endcase
  end

  assign grant = state[NumPorts:1];

endmodule

`default_nettype wire

// File: rtl/holdTimer.sv
`timescale 1ns/10ps
`default_nettype none

module holdTimer
(
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flit_u inFlit,
  input  logic          runTimer,
  output logic          timesUp
);
  import nocPkg::*;

  logic [LenWidth-1:0] limit;
  logic [LenWidth-1:0] count;

  // length latch follows every head flit on this input, granted or not
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (inFlit.head.id == HEAD)
    begin
      limit <= inFlit.head.len;
    end
  end

  // counts cycles of the held grant, restarts whenever the hold drops
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (runTimer)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  // count starts at zero on the first granted cycle, so the hold lasts limit+1
  assign timesUp = (count == limit);

endmodule

`default_nettype wire

// File: rtl/nocPkg.sv
`default_nettype none

package nocPkg;

  // flit format
  localparam int FlitWidth = 16;
  localparam int IdWidth = 3;
  localparam int LenWidth = 12;
  localparam int PayloadWidth = FlitWidth - IdWidth;
  localparam int SpareWidth = FlitWidth - IdWidth - LenWidth;

  // ports of one router output
  localparam int NumPorts = 5;

  typedef enum logic [IdWidth-1:0]
  {
    HEAD = 3'b001,
    BODY = 3'b010,
    TAIL = 3'b100
  } flitId_e;

  typedef enum logic [2:0]
  {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    West  = 3'd3,
    South = 3'd4
  } portIdx_e;

  // head flit carries the packet length in flit times
  typedef struct packed
  {
    flitId_e               id;
    logic [LenWidth-1:0]   len;
    logic [SpareWidth-1:0] spare;
  } flitHead_t;

  typedef struct packed
  {
    flitId_e                 id;
    logic [PayloadWidth-1:0] payload;
  } flitBody_t;

  // same word, read as head or as body depending on id
  typedef union packed
  {
    flitHead_t head;
    flitBody_t body;
  } flit_u;

  typedef struct packed
  {
    logic  req;
    flit_u flit;
  } portIn_t;

endpackage

`default_nettype wire
